/* Bender.yml */
package:
  name: mat_decd

sources:
  - files:
      - hdl/mat_decd_pkg.sv
      - hdl/mat_inst_if.sv
      - hdl/mat_inst_latch.sv
      - hdl/mat_alu_decd.sv
      - hdl/mat_lsu_decd.sv
      - hdl/mat_cfg_decd.sv
      - hdl/mat_decd.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_mat_decd.sv

/* bench/tb_clk_gen.sv */
// testbench clock and reset source, free running clock with a synchronous reset pulse
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0; // released off the edge like other inputs
    end

endmodule

/* bench/tb_mat_decd.sv */
// testbench for the matrix decode stage, random opcodes checked against a decode model
`timescale 1ns/100ps

module tb_mat_decd;

    localparam logic [31:0] SEED  = 32'h0c71_7cc8;
    localparam int RST_CYCLES     = 10;
    localparam int IDLE_CYCLES    = 8;
    localparam int SWEEP_CYCLES   = 256; // every {func, uop, size} key
    localparam int ILLEGAL_CYCLES = 200;
    localparam int STREAM_CYCLES  = 400;
    localparam int TOTAL_CYCLES   = RST_CYCLES + IDLE_CYCLES + 3 * SWEEP_CYCLES
                                  + ILLEGAL_CYCLES + STREAM_CYCLES + 6;
    localparam int WATCHDOG_NS    = 2 * (TOTAL_CYCLES + 20) * 10;

    logic                          clk;
    logic                          rst;
    logic                          decd_inst_vld;
    logic [31:0]                   decd_opcode;
    mat_decd_pkg::mat_type_t       decd_type;
    logic                          mat_meta_vld;
    mat_decd_pkg::mat_alu_meta_t   mat_alu_meta;
    mat_decd_pkg::mat_lsu_meta_t   mat_lsu_meta;
    mat_decd_pkg::mat_cfg_meta_t   mat_cfg_meta;
    mat_decd_pkg::mat_uimm7_t      mat_cfg_uimm7;

    logic                          m_vld; // model of the decode slot
    mat_decd_pkg::mat_type_t       m_type;
    logic [31:0]                   m_opc;
    logic [31:0]                   rng_state;
    string                         test_name;
    int                            test_errs;
    int                            total_errs;
    int                            n_checks;
    int                            n_tests;
    int                            n_bad_tests;

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(RST_CYCLES)) u_clk_gen (.clk(clk), .rst(rst));

    mat_decd u_mat_decd (
        .forever_cpuclk (clk),
        .rst            (rst),
        .decd_inst_vld  (decd_inst_vld),
        .decd_opcode    (decd_opcode),
        .decd_type      (decd_type),
        .mat_meta_vld   (mat_meta_vld),
        .mat_alu_meta   (mat_alu_meta),
        .mat_lsu_meta   (mat_lsu_meta),
        .mat_cfg_meta   (mat_cfg_meta),
        .mat_cfg_uimm7  (mat_cfg_uimm7)
    );

    always @(posedge clk)
    begin
        if (rst)
        begin
            m_vld  <= 1'b0;
            m_type <= '0;
            m_opc  <= '0;
        end
        else
        begin
            m_vld <= decd_inst_vld;
            if (decd_inst_vld) // idle slots keep the old opcode
            begin
                m_type <= decd_type;
                m_opc  <= decd_opcode;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic mat_decd_pkg::mat_type_t class_tag(input logic [1:0] cls);
        case (cls)
            2'd0    : return mat_decd_pkg::MAT_CAL;
            2'd1    : return mat_decd_pkg::MAT_LSU;
            2'd2    : return mat_decd_pkg::MAT_CFG;
            default : return mat_decd_pkg::MAT_SPECIAL_MOV;
        endcase
    endfunction

    // a defined {func, uop, size} key for the given class
    function automatic logic [7:0] legal_key(input logic [1:0] cls, input logic [31:0] r);
        logic [3:0] func;
        logic [2:0] uop;
        logic       size;
        func = r[3:0];
        uop  = r[6:4];
        size = r[7];
        if (cls == 2'd0)
        begin
            func = 4'(r[7:0] % 10);
            uop  = (func == 4'd0) ? 3'(r[9:8] % 3) : ((func >= 4'd3) ? {1'b0, r[9:8]} : 3'd0);
            size = (func == 4'd1) ? r[10] : 1'b0; // fwmmacc is the only size 1
        end
        else if (cls == 2'd1)
        begin
            func = r[0] ? 4'b0010 : 4'b0000;
            uop  = {2'b10, r[1]};
            size = (func == 4'b0000) ? r[2] : 1'b0;
        end
        else if (cls == 2'd2)
        begin
            func = r[2] ? 4'b1111 : {r[3], 3'(r[5:4] % 3)};
            uop  = 3'b111;
            size = (func == 4'b1111) ? 1'b0 : r[6];
        end
        return {func, uop, size};
    endfunction

    function automatic mat_decd_pkg::mat_alu_meta_t decode_alu(input logic vld,
        input mat_decd_pkg::mat_type_t typ, input logic [31:0] opc);
        logic [3:0]  func;
        logic [2:0]  uop;
        logic [10:0] op;
        logic        dv;
        func = opc[31:28];
        uop  = opc[27:25];
        op   = '0;
        if (vld && (typ == mat_decd_pkg::MAT_CAL))
        begin
            if ((func == 4'd0) && !opc[24] && (uop <= 3'd2))
                op = 11'd1; // mmov
            else if ((func == 4'd1) && (uop == 3'd0))
                op = opc[24] ? 11'd4 : 11'd2;
            else if ((func == 4'd2) && (uop == 3'd0) && !opc[24])
                op = 11'd8;
            else if ((func >= 4'd3) && (func <= 4'd9) && (uop <= 3'd3) && !opc[24])
                op = 11'd1 << (func + 4'd1); // madd .. mmulh
        end
        dv = (op != '0);
        return {op, dv, opc[17:15],
                dv && (func != 4'd0), (opc[9:7] == 3'd1) || (opc[9:7] == 3'd3), opc[23:21],
                dv && (uop != 3'd3), (opc[9:7] == 3'd1) || (opc[9:7] == 3'd2), opc[20:18],
                dv && (uop == 3'd2), opc[9:7], opc[11:10]};
    endfunction

    function automatic mat_decd_pkg::mat_lsu_meta_t decode_lsu(input logic vld,
        input mat_decd_pkg::mat_type_t typ, input logic [31:0] opc);
        logic ld;
        logic st;
        logic nfv;
        ld  = 1'b0;
        st  = 1'b0;
        nfv = 1'b0;
        if (vld && (typ == mat_decd_pkg::MAT_LSU)
            && ((opc[31:28] == 4'd0) || ((opc[31:28] == 4'd2) && !opc[24])))
        begin
            ld  = (opc[27:25] == 3'b100);
            st  = (opc[27:25] == 3'b101);
            nfv = (opc[31:28] == 4'd2) && (ld || st); // whole register form
        end
        return {st, ld, ld, opc[9:7], st, opc[9:7], nfv, opc[22:20], opc[11:10]};
    endfunction

    function automatic mat_decd_pkg::mat_cfg_meta_t decode_cfg(input logic vld,
        input mat_decd_pkg::mat_type_t typ, input logic [31:0] opc);
        logic [3:0] op;
        op = '0;
        if (vld && (typ == mat_decd_pkg::MAT_CFG) && (opc[27:25] == 3'b111))
        begin
            if ((opc[31:28] == 4'b1111) && !opc[24])
                op = 4'b1000;
            else if (opc[30:28] <= 3'd2)
                op = 4'b0001 << opc[30:28]; // k, m, n
        end
        return op;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got,
        input logic [31:0] exp);
        $display("Mismatch %s: got %h expected %h (%s, %0t ns)", sig, got, exp, test_name, $time);
        test_errs++;
    endtask

    task automatic check_outputs(input logic exp_vld, input mat_decd_pkg::mat_alu_meta_t exp_alu,
        input mat_decd_pkg::mat_lsu_meta_t exp_lsu, input mat_decd_pkg::mat_cfg_meta_t exp_cfg,
        input mat_decd_pkg::mat_uimm7_t exp_uimm7);
        n_checks++;
        if (mat_meta_vld !== exp_vld) report_mismatch("mat_meta_vld", mat_meta_vld, exp_vld);
        if (mat_alu_meta !== exp_alu) report_mismatch("mat_alu_meta", mat_alu_meta, exp_alu);
        if (mat_lsu_meta !== exp_lsu) report_mismatch("mat_lsu_meta", mat_lsu_meta, exp_lsu);
        if (mat_cfg_meta !== exp_cfg) report_mismatch("mat_cfg_meta", mat_cfg_meta, exp_cfg);
        if (mat_cfg_uimm7 !== exp_uimm7) report_mismatch("mat_cfg_uimm7", mat_cfg_uimm7, exp_uimm7);
    endtask

    // check the slot filled at this edge, then drive the next input
    task automatic step(input logic vld, input mat_decd_pkg::mat_type_t typ,
        input logic [31:0] opc);
        @(posedge clk);
        #1;
        check_outputs(m_vld, decode_alu(m_vld, m_type, m_opc), decode_lsu(m_vld, m_type, m_opc),
                      decode_cfg(m_vld, m_type, m_opc), m_opc[24:18]);
        decd_inst_vld = vld;
        decd_type     = typ;
        decd_opcode   = opc;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        n_tests++;
        total_errs += test_errs;
        if (test_errs != 0)
            n_bad_tests++;
        $display("test %0d %s: %0d errors", n_tests, test_name, test_errs);
    endtask

    task automatic sweep_class(input mat_decd_pkg::mat_type_t typ);
        logic [31:0] opc;
        for (int k = 0; k < SWEEP_CYCLES; k++)
        begin
            opc = next_rand();
            opc[31:24] = k[7:0];
            step(1'b1, typ, opc);
        end
        step(1'b0, '0, next_rand()); // drain the last key
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] opc;
        decd_inst_vld = 1'b0;
        decd_opcode   = '0;
        decd_type     = '0;
        rng_state     = SEED;
        total_errs    = 0;
        n_checks      = 0;
        n_tests       = 0;
        n_bad_tests   = 0;

        start_test("reset");
        @(posedge clk);
        #1;
        check_outputs(1'b0, '0, '0, '0, '0);
        @(negedge rst);
        for (int i = 0; i < IDLE_CYCLES; i++)
        begin
            step(1'b0, class_tag(i[1:0]), next_rand()); // idle input must not load
            check_outputs(1'b0, '0, '0, '0, '0);
        end
        end_test();

        start_test("arithmetic decode");
        sweep_class(mat_decd_pkg::MAT_CAL);
        end_test();

        start_test("load/store decode");
        sweep_class(mat_decd_pkg::MAT_LSU);
        end_test();

        start_test("configuration decode");
        sweep_class(mat_decd_pkg::MAT_CFG);
        end_test();

        start_test("illegal and unused");
        for (int i = 0; i < ILLEGAL_CYCLES; i++)
        begin
            r   = next_rand();
            opc = next_rand();
            case (i % 4)
                0       : step(1'b1, mat_decd_pkg::MAT_SPECIAL_MOV, opc);
                1       : step(1'b1, r[3:0], opc); // raw tag bits
                2       : step(1'b0, mat_decd_pkg::MAT_CAL, {legal_key(2'd0, r), opc[23:0]});
                default : step(1'b1, mat_decd_pkg::MAT_CAL, {4'(10 + r[7:0] % 6), opc[27:0]});
            endcase
        end
        step(1'b0, '0, next_rand());
        end_test();

        start_test("back-to-back stream");
        for (int i = 0; i < STREAM_CYCLES; i++)
        begin
            r   = next_rand();
            opc = next_rand();
            if (r[4])
                opc[31:24] = legal_key(r[6:5], next_rand());
            step(r[3:0] != 4'h0, r[7] ? r[11:8] : class_tag(r[6:5]), opc);
        end
        step(1'b0, '0, next_rand());
        end_test();

        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
                 n_tests, n_bad_tests, n_checks, total_errs);
        if (total_errs == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* hdl/mat_alu_decd.sv */
// arithmetic class decoder producing the arithmetic metadata record
`timescale 1ns/100ps

module mat_alu_decd (
    mat_inst_if.decd                    inst,
    output mat_decd_pkg::mat_alu_meta_t alu_meta
);

    logic                  cal_sel;
    mat_decd_pkg::mat_op_t op;
    logic                  dstm_vld;
    logic                  src0m_vld;
    logic                  src1m_vld;
    logic                  uimm3_vld;
    logic                  src0m_unsigned;
    logic                  src1m_unsigned;

    assign cal_sel = inst.vld && (inst.mat_type == mat_decd_pkg::MAT_CAL);

    // key is {func, uop, size}
    // uop 000/001/010/011 -> .mm/.mv.x/.mv.i/.mx
    always_comb
    begin
        op = '0;
        if (cal_sel)
        begin
            casez ({inst.func, inst.uop, inst.size})
                8'b0000_00?_0,
                8'b0000_010_0 : op = mat_decd_pkg::MAT_CAL_MMOV;     // no .mx form
                8'b0001_000_0 : op = mat_decd_pkg::MAT_CAL_FMMACC;
                8'b0001_000_1 : op = mat_decd_pkg::MAT_CAL_FWMMACC;  // widening
                8'b0010_000_0 : op = mat_decd_pkg::MAT_CAL_MMAQA;
                8'b0011_0??_0 : op = mat_decd_pkg::MAT_CAL_MADD;
                8'b0100_0??_0 : op = mat_decd_pkg::MAT_CAL_MSUB;
                8'b0101_0??_0 : op = mat_decd_pkg::MAT_CAL_MSRA;
                8'b0110_0??_0 : op = mat_decd_pkg::MAT_CAL_MN4CLIP;
                8'b0111_0??_0 : op = mat_decd_pkg::MAT_CAL_MN4CLIPU;
                8'b1000_0??_0 : op = mat_decd_pkg::MAT_CAL_MMUL;
                8'b1001_0??_0 : op = mat_decd_pkg::MAT_CAL_MMULH;
                default       : op = '0;
            endcase
        end
    end

    // every legal encoding writes md
    assign dstm_vld  = |op;
    assign src0m_vld = dstm_vld && (inst.uop != 3'b011);   // .mx takes src0 from a gpr
    assign src1m_vld = dstm_vld && (op != mat_decd_pkg::MAT_CAL_MMOV);
    assign uimm3_vld = dstm_vld && (inst.uop == 3'b010);   // .mv.i

    // the uimm3 bits double as source signedness for mmaqa
    always_comb
    begin
        case (inst.dstm_lo)
            3'b001 : // both unsigned
            begin
                src0m_unsigned = 1'b1;
                src1m_unsigned = 1'b1;
            end
            3'b010 :
            begin
                src0m_unsigned = 1'b1;
                src1m_unsigned = 1'b0;
            end
            3'b011 :
            begin
                src0m_unsigned = 1'b0;
                src1m_unsigned = 1'b1;
            end
            default : // 000 and the reserved codes
            begin
                src0m_unsigned = 1'b0;
                src1m_unsigned = 1'b0;
            end
        endcase
    end

    assign alu_meta[mat_decd_pkg::MAT_ALU_OP -: mat_decd_pkg::MAT_OP_W] = op;
    assign alu_meta[mat_decd_pkg::MAT_ALU_DSTM_VLD] = dstm_vld;
    assign alu_meta[mat_decd_pkg::MAT_ALU_DSTM_IDX -: mat_decd_pkg::MAT_IDX_W] =
        inst.dstm_hi;
    assign alu_meta[mat_decd_pkg::MAT_ALU_SRC1M_VLD] = src1m_vld;
    assign alu_meta[mat_decd_pkg::MAT_ALU_SRC1M_UNSIGNED] = src1m_unsigned;
    assign alu_meta[mat_decd_pkg::MAT_ALU_SRC1M_IDX -: mat_decd_pkg::MAT_IDX_W] =
        inst.srcm1;
    assign alu_meta[mat_decd_pkg::MAT_ALU_SRC0M_VLD] = src0m_vld;
    assign alu_meta[mat_decd_pkg::MAT_ALU_SRC0M_UNSIGNED] = src0m_unsigned;
    assign alu_meta[mat_decd_pkg::MAT_ALU_SRC0M_IDX -: mat_decd_pkg::MAT_IDX_W] =
        inst.srcm0;
    assign alu_meta[mat_decd_pkg::MAT_ALU_UIMM3_VLD] = uimm3_vld;
    assign alu_meta[mat_decd_pkg::MAT_ALU_UIMM3 -: mat_decd_pkg::MAT_IDX_W] =
        inst.dstm_lo;
    assign alu_meta[mat_decd_pkg::MAT_ALU_ELM_WIDTH -: mat_decd_pkg::MAT_ELM_W] =
        inst.elm_width;

endmodule

/* hdl/mat_cfg_decd.sv */
// configuration class decoder producing the config op and its immediate
`timescale 1ns/100ps

module mat_cfg_decd (
    mat_inst_if.decd                    inst,
    output mat_decd_pkg::mat_cfg_meta_t cfg_meta,
    output mat_decd_pkg::mat_uimm7_t    cfg_uimm7
);

    logic                  cfg_sel;
    mat_decd_pkg::mat_op_t op;

    assign cfg_sel = inst.vld
                  && (inst.mat_type == mat_decd_pkg::MAT_CFG)
                  && (inst.uop == mat_decd_pkg::MAT_CFG_UOP);

    always_comb
    begin
        op = '0;
        if (cfg_sel)
        begin
            if ((inst.func == mat_decd_pkg::MAT_CFG_FUNC_ALL) && !inst.size)
                op = mat_decd_pkg::MAT_OP_W'(mat_decd_pkg::MAT_CFG_ALL); // mcfg from gpr
            else
            begin
                // func[3] picks gpr or immediate source, not decoded here
                case (inst.func[2:0])
                    3'b000  : op = mat_decd_pkg::MAT_OP_W'(mat_decd_pkg::MAT_CFG_K);
                    3'b001  : op = mat_decd_pkg::MAT_OP_W'(mat_decd_pkg::MAT_CFG_M);
                    3'b010  : op = mat_decd_pkg::MAT_OP_W'(mat_decd_pkg::MAT_CFG_N);
                    default : op = '0;
                endcase
            end
        end
    end

    assign cfg_meta  = op[mat_decd_pkg::MAT_CFG_OP_W-1:0];
    assign cfg_uimm7 = inst.uimm7; // passed whatever the class

endmodule

/* hdl/mat_decd.sv */
// matrix decode stage top: one latched slot feeding the three class decoders
`timescale 1ns/100ps

module mat_decd (
    input  logic                                  forever_cpuclk,
    input  logic                                  rst,
    input  logic                                  decd_inst_vld,
    input  logic [mat_decd_pkg::MAT_OPCODE_W-1:0] decd_opcode,
    input  mat_decd_pkg::mat_type_t               decd_type,
    output logic                                  mat_meta_vld,
    output mat_decd_pkg::mat_alu_meta_t           mat_alu_meta,
    output mat_decd_pkg::mat_lsu_meta_t           mat_lsu_meta,
    output mat_decd_pkg::mat_cfg_meta_t           mat_cfg_meta,
    output mat_decd_pkg::mat_uimm7_t              mat_cfg_uimm7
);

    // latched fields, one writer and three readers
    mat_inst_if u_inst_if ();

    mat_inst_latch u_inst_latch (
        .forever_cpuclk (forever_cpuclk),
        .rst            (rst),
        .decd_inst_vld  (decd_inst_vld),
        .decd_opcode    (decd_opcode),
        .decd_type      (decd_type),
        .inst           (u_inst_if.latch)
    );

    mat_alu_decd u_alu_decd (
        .inst     (u_inst_if.decd),
        .alu_meta (mat_alu_meta)
    );

    mat_lsu_decd u_lsu_decd (
        .inst     (u_inst_if.decd),
        .lsu_meta (mat_lsu_meta)
    );

    mat_cfg_decd u_cfg_decd (
        .inst      (u_inst_if.decd),
        .cfg_meta  (mat_cfg_meta),
        .cfg_uimm7 (mat_cfg_uimm7)
    );

    assign mat_meta_vld = u_inst_if.vld; // records line up with the latched valid

endmodule

/* hdl/mat_decd_pkg.sv */
// matrix decode package with class tags, op codes, field types and record layouts
package mat_decd_pkg;

    // field widths
    localparam int MAT_OPCODE_W = 32;
    localparam int MAT_TYPE_W   = 4;
    localparam int MAT_OP_W     = 11;
    localparam int MAT_FUNC_W   = 4;
    localparam int MAT_UOP_W    = 3;
    localparam int MAT_IDX_W    = 3;
    localparam int MAT_ELM_W    = 2;
    localparam int MAT_UIMM7_W  = 7;

    localparam int MAT_LSU_OP_W = 2;
    localparam int MAT_CFG_OP_W = 4;

    localparam int MAT_ALU_DATA_W = 31;
    localparam int MAT_LSU_DATA_W = 16;

    typedef logic [MAT_TYPE_W-1:0]     mat_type_t;      // one-hot class tag
    typedef logic [MAT_OP_W-1:0]       mat_op_t;        // one-hot op code
    typedef logic [MAT_IDX_W-1:0]      mat_idx_t;       // matrix register index
    typedef logic [MAT_ELM_W-1:0]      mat_elm_width_t; // 00/01/10/11 -> 8/16/32/64
    typedef logic [MAT_ALU_DATA_W-1:0] mat_alu_meta_t;
    typedef logic [MAT_LSU_DATA_W-1:0] mat_lsu_meta_t;
    typedef logic [MAT_CFG_OP_W-1:0]   mat_cfg_meta_t;
    typedef logic [MAT_UIMM7_W-1:0]    mat_uimm7_t;

    // instruction classes
    localparam mat_type_t MAT_CAL         = 4'b0001;
    localparam mat_type_t MAT_LSU         = 4'b0010;
    localparam mat_type_t MAT_CFG         = 4'b0100;
    localparam mat_type_t MAT_SPECIAL_MOV = 4'b1000; // nothing decoded for this class

    // arithmetic ops
    localparam mat_op_t MAT_CAL_MMOV     = 11'b000_0000_0001;
    localparam mat_op_t MAT_CAL_FMMACC   = 11'b000_0000_0010;
    localparam mat_op_t MAT_CAL_FWMMACC  = 11'b000_0000_0100;
    localparam mat_op_t MAT_CAL_MMAQA    = 11'b000_0000_1000;
    localparam mat_op_t MAT_CAL_MADD     = 11'b000_0001_0000;
    localparam mat_op_t MAT_CAL_MSUB     = 11'b000_0010_0000;
    localparam mat_op_t MAT_CAL_MSRA     = 11'b000_0100_0000;
    localparam mat_op_t MAT_CAL_MN4CLIP  = 11'b000_1000_0000; // signed clip
    localparam mat_op_t MAT_CAL_MN4CLIPU = 11'b001_0000_0000; // unsigned clip
    localparam mat_op_t MAT_CAL_MMUL     = 11'b010_0000_0000;
    localparam mat_op_t MAT_CAL_MMULH    = 11'b100_0000_0000;

    // load/store ops
    localparam logic [MAT_LSU_OP_W-1:0] MAT_LSU_LOAD  = 2'b01;
    localparam logic [MAT_LSU_OP_W-1:0] MAT_LSU_STORE = 2'b10;

    // configuration ops
    localparam logic [MAT_CFG_OP_W-1:0] MAT_CFG_K   = 4'b0001;
    localparam logic [MAT_CFG_OP_W-1:0] MAT_CFG_M   = 4'b0010;
    localparam logic [MAT_CFG_OP_W-1:0] MAT_CFG_N   = 4'b0100;
    localparam logic [MAT_CFG_OP_W-1:0] MAT_CFG_ALL = 4'b1000;

    localparam logic [MAT_FUNC_W-1:0] MAT_CFG_FUNC_ALL = 4'b1111; // mcfg
    localparam logic [MAT_UOP_W-1:0]  MAT_CFG_UOP      = 3'b111;

    // arithmetic record, msb of each field
    localparam int MAT_ALU_OP             = 30; // 30:20
    localparam int MAT_ALU_DSTM_VLD       = 19;
    localparam int MAT_ALU_DSTM_IDX       = 18; // 18:16
    localparam int MAT_ALU_SRC1M_VLD      = 15;
    localparam int MAT_ALU_SRC1M_UNSIGNED = 14;
    localparam int MAT_ALU_SRC1M_IDX      = 13; // 13:11
    localparam int MAT_ALU_SRC0M_VLD      = 10;
    localparam int MAT_ALU_SRC0M_UNSIGNED = 9;
    localparam int MAT_ALU_SRC0M_IDX      = 8;  // 8:6
    localparam int MAT_ALU_UIMM3_VLD      = 5;
    localparam int MAT_ALU_UIMM3          = 4;  // 4:2
    localparam int MAT_ALU_ELM_WIDTH      = 1;  // 1:0

    // load/store record, msb of each field
    localparam int MAT_LSU_OP        = 15; // 15:14
    localparam int MAT_LSU_DSTM_VLD  = 13;
    localparam int MAT_LSU_DSTM_IDX  = 12; // 12:10
    localparam int MAT_LSU_SRC2M_VLD = 9;
    localparam int MAT_LSU_SRC2M_IDX = 8;  // 8:6
    localparam int MAT_LSU_NF_VLD    = 5;
    localparam int MAT_LSU_NF        = 4;  // 4:2, 000/001/011/111 -> 1/2/4/8 regs
    localparam int MAT_LSU_ELM_WIDTH = 1;  // 1:0

endpackage

/* hdl/mat_inst_if.sv */
// latched matrix instruction fields shared by the latch and the class decoders
`timescale 1ns/100ps

interface mat_inst_if;

    logic                             vld;       // slot holds an instruction
    mat_decd_pkg::mat_type_t          mat_type;
    logic [mat_decd_pkg::MAT_FUNC_W-1:0] func;   // 31:28
    logic [mat_decd_pkg::MAT_UOP_W-1:0]  uop;    // 27:25
    logic                             size;      // 24
    mat_decd_pkg::mat_idx_t           dstm_hi;   // arithmetic md
    mat_decd_pkg::mat_idx_t           dstm_lo;   // load md, store ms3 or uimm3
    mat_decd_pkg::mat_idx_t           srcm0;
    mat_decd_pkg::mat_idx_t           srcm1;
    mat_decd_pkg::mat_idx_t           nf;
    mat_decd_pkg::mat_elm_width_t     elm_width;
    mat_decd_pkg::mat_uimm7_t         uimm7;

    modport latch (
        output vld, mat_type, func, uop, size, dstm_hi, dstm_lo,
        output srcm0, srcm1, nf, elm_width, uimm7
    );

    modport decd (
        input vld, mat_type, func, uop, size, dstm_hi, dstm_lo,
        input srcm0, srcm1, nf, elm_width, uimm7
    );

endinterface

/* hdl/mat_inst_latch.sv */
// decode slot register holding valid, class tag and opcode, split into fields
`timescale 1ns/100ps

module mat_inst_latch (
    input  logic                                  forever_cpuclk,
    input  logic                                  rst,
    input  logic                                  decd_inst_vld,
    input  logic [mat_decd_pkg::MAT_OPCODE_W-1:0] decd_opcode,
    input  mat_decd_pkg::mat_type_t               decd_type,
    mat_inst_if.latch                             inst
);

    logic                                  vld_q;
    mat_decd_pkg::mat_type_t               type_q;
    logic [mat_decd_pkg::MAT_OPCODE_W-1:0] opcode_q;

    always_ff @(posedge forever_cpuclk)
    begin
        if (rst)
        begin
            vld_q    <= 1'b0;
            type_q   <= '0;
            opcode_q <= '0;
        end
        else
        begin
            vld_q <= decd_inst_vld;
            if (decd_inst_vld) // hold the last instruction in idle slots
            begin
                type_q   <= decd_type;
                opcode_q <= decd_opcode;
            end
        end
    end

    assign inst.vld       = vld_q;
    assign inst.mat_type  = type_q;
    assign inst.func      = opcode_q[31:28];
    assign inst.uop       = opcode_q[27:25];
    assign inst.size      = opcode_q[24];
    assign inst.dstm_hi   = opcode_q[17:15];
    assign inst.dstm_lo   = opcode_q[9:7];
    assign inst.srcm0     = opcode_q[20:18];
    assign inst.srcm1     = opcode_q[23:21];
    assign inst.nf        = opcode_q[22:20]; // overlaps srcm0/srcm1 bits
    assign inst.elm_width = opcode_q[11:10];
    assign inst.uimm7     = opcode_q[24:18];

endmodule

/* hdl/mat_lsu_decd.sv */
// load/store class decoder producing the load/store metadata record
`timescale 1ns/100ps

module mat_lsu_decd (
    mat_inst_if.decd                    inst,
    output mat_decd_pkg::mat_lsu_meta_t lsu_meta
);

    logic                  lsu_sel;
    mat_decd_pkg::mat_op_t op;
    logic                  dstm_vld;
    logic                  src2m_vld;
    logic                  nf_vld;

    assign lsu_sel = inst.vld && (inst.mat_type == mat_decd_pkg::MAT_LSU);

    always_comb
    begin
        op        = '0;
        dstm_vld  = 1'b0;
        src2m_vld = 1'b0;
        nf_vld    = 1'b0;
        if (lsu_sel)
        begin
            casez ({inst.func, inst.uop, inst.size})
                8'b0000_100_? : // element load, width from elm_width
                begin
                    op       = mat_decd_pkg::MAT_OP_W'(mat_decd_pkg::MAT_LSU_LOAD);
                    dstm_vld = 1'b1;
                end
                8'b0000_101_? : // element store
                begin
                    op        = mat_decd_pkg::MAT_OP_W'(mat_decd_pkg::MAT_LSU_STORE);
                    src2m_vld = 1'b1;
                end
                8'b0010_100_0 : // whole register load, nf regs
                begin
                    op       = mat_decd_pkg::MAT_OP_W'(mat_decd_pkg::MAT_LSU_LOAD);
                    dstm_vld = 1'b1;
                    nf_vld   = 1'b1;
                end
                8'b0010_101_0 : // whole register store
                begin
                    op        = mat_decd_pkg::MAT_OP_W'(mat_decd_pkg::MAT_LSU_STORE);
                    src2m_vld = 1'b1;
                    nf_vld    = 1'b1;
                end
                default : ;
            endcase
        end
    end

    // op record takes the low bits of the shared op code
    assign lsu_meta[mat_decd_pkg::MAT_LSU_OP -: mat_decd_pkg::MAT_LSU_OP_W] =
        op[mat_decd_pkg::MAT_LSU_OP_W-1:0];
    assign lsu_meta[mat_decd_pkg::MAT_LSU_DSTM_VLD] = dstm_vld;
    assign lsu_meta[mat_decd_pkg::MAT_LSU_DSTM_IDX -: mat_decd_pkg::MAT_IDX_W] =
        inst.dstm_lo;
    assign lsu_meta[mat_decd_pkg::MAT_LSU_SRC2M_VLD] = src2m_vld;
    assign lsu_meta[mat_decd_pkg::MAT_LSU_SRC2M_IDX -: mat_decd_pkg::MAT_IDX_W] =
        inst.dstm_lo; // ms3 shares bits 9:7 with md
    assign lsu_meta[mat_decd_pkg::MAT_LSU_NF_VLD] = nf_vld;
    assign lsu_meta[mat_decd_pkg::MAT_LSU_NF -: mat_decd_pkg::MAT_IDX_W] = inst.nf;
    assign lsu_meta[mat_decd_pkg::MAT_LSU_ELM_WIDTH -: mat_decd_pkg::MAT_ELM_W] =
        inst.elm_width;

endmodule

/* mat_decd.f */
hdl/mat_decd_pkg.sv
hdl/mat_inst_if.sv
hdl/mat_inst_latch.sv
hdl/mat_alu_decd.sv
hdl/mat_lsu_decd.sv
hdl/mat_cfg_decd.sv
hdl/mat_decd.sv
bench/tb_clk_gen.sv
bench/tb_mat_decd.sv
